/* hdl/fmap_pkg.sv */
package fmap_pkg;

    localparam int PIXEL_W    = 16;
    localparam int MAP_W      = 16;
    localparam int SEG_PIXELS = 16;  // pixels per segment and per burst
    localparam int MEM_ADDR_W = 32;
    localparam int MEM_DATA_W = 32;
    localparam int PX_ADDR_W  = 20;
    localparam int LEN_W      = 4;   // read length in words

    typedef logic [PIXEL_W-1:0]    pixel_t;
    typedef logic [MEM_DATA_W-1:0] mem_word_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [PX_ADDR_W-1:0]  px_addr_t;
    typedef logic [MAP_W-1:0]      sparsity_map_t;

    // up to 16 set bits
    typedef logic [4:0] pop_count_t;

    typedef logic [8:0] dim_t;
    typedef logic [9:0] fmap_cnt_t;

endpackage

/* hdl/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int AW = $clog2(DEPTH);

    payload_t       mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic           do_push;
    logic           do_pop;

    assign empty    = (count == '0);
    assign do_push  = push && (count != (AW+1)'(DEPTH));
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];  // head shown before pop

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

endmodule

/* hdl/popcount_unit.sv */
`timescale 1ns/100ps

module popcount_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    map_load,
    input  fmap_pkg::sparsity_map_t map_in,
    output logic                    pop_done,
    output fmap_pkg::pop_count_t    pop_count
);

    fmap_pkg::sparsity_map_t map_q;
    logic [1:0]              left;

    function automatic logic [2:0] ones4(input logic [3:0] n);
        ones4 = 3'(n[0]) + 3'(n[1]) + 3'(n[2]) + 3'(n[3]);
    endfunction

    // first nibble is counted in the load cycle itself
    always_ff @(posedge clk) begin
        if (map_load) map_q <= map_in << 4;
        else if (left != 2'd0) map_q <= map_q << 4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left      <= '0;
            pop_done  <= 1'b0;
            pop_count <= '0;
        end else begin
            pop_done <= 1'b0;
            if (map_load) begin
                pop_count <= {2'b00, ones4(map_in[fmap_pkg::MAP_W-1 -: 4])};
                left      <= 2'd3;
            end else if (left != 2'd0) begin
                pop_count <= pop_count + {2'b00, ones4(map_q[fmap_pkg::MAP_W-1 -: 4])};
                left      <= left - 1'b1;
                pop_done  <= (left == 2'd1);  // last nibble in
            end
        end
    end

endmodule

/* hdl/pixel_expander.sv */
`timescale 1ns/100ps

module pixel_expander (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    map_load,
    input  fmap_pkg::sparsity_map_t map_in,
    input  logic                    expand_start,
    input  fmap_pkg::mem_word_t     word_data,
    input  logic                    word_empty,
    output logic                    word_pop,
    output logic                    pixel_push,
    output fmap_pkg::pixel_t        pixel_out,
    output logic                    expand_done
);

    fmap_pkg::sparsity_map_t map_sr;
    logic [4:0]              cnt;    // columns still to emit
    logic                    half;   // upper half of head word is next
    logic                    active;
    logic                    last;
    logic                    bit_set;
    logic                    need_pop;

    assign active  = (cnt != 5'd0);
    assign last    = (cnt == 5'd1);
    assign bit_set = map_sr[fmap_pkg::MAP_W-1];  // column 0 first

    always_comb begin
        pixel_out = '0;
        if (bit_set) begin
            pixel_out = half ? word_data[2*fmap_pkg::PIXEL_W-1 -: fmap_pkg::PIXEL_W]
                             : word_data[fmap_pkg::PIXEL_W-1:0];
        end
    end

    // on the last column any half-used word goes too, dropping the padding
    assign need_pop   = last ? (bit_set || half) : (bit_set && half);
    assign word_pop   = active && need_pop && !word_empty;
    assign pixel_push = active;

    always_ff @(posedge clk) begin
        if (map_load) map_sr <= map_in;
        else if (active) map_sr <= map_sr << 1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            half        <= 1'b0;
            expand_done <= 1'b0;
        end else begin
            expand_done <= active && last;
            if (expand_start) begin
                cnt  <= 5'(fmap_pkg::SEG_PIXELS);
                half <= 1'b0;
            end else if (active) begin
                cnt <= cnt - 1'b1;
                if (bit_set) half <= ~half;
            end
        end
    end

endmodule

/* hdl/position_tracker.sv */
`timescale 1ns/100ps

module position_tracker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  fmap_pkg::dim_t       cfg_width,
    input  fmap_pkg::dim_t       cfg_height,
    input  fmap_pkg::fmap_cnt_t  cfg_num_fmap,
    input  logic                 seg_done,
    output fmap_pkg::px_addr_t   px_addr,
    output logic                 row_end,
    output logic                 frame_end,
    output logic                 track_write,
    output fmap_pkg::px_addr_t   track_din
);

    fmap_pkg::dim_t                   width_q;
    fmap_pkg::dim_t                   height_q;
    fmap_pkg::fmap_cnt_t              num_fmap_q;
    fmap_pkg::dim_t                   col;
    fmap_pkg::dim_t                   row;
    fmap_pkg::fmap_cnt_t              fmap;
    logic [$bits(fmap_pkg::dim_t):0]  col_sum;  // extra bit as col + 16 may pass 511
    logic                             col_wrap;
    logic                             fmap_wrap;

    assign col_sum   = {1'b0, col} + {1'b0, fmap_pkg::dim_t'(fmap_pkg::SEG_PIXELS)};
    assign col_wrap  = col_sum >= {1'b0, width_q};
    assign fmap_wrap = col_wrap && (fmap + 1'b1 == num_fmap_q);
    assign row_end   = seg_done && fmap_wrap;
    assign frame_end = (row + 1'b1 == height_q);  // last row in progress

    assign track_write = row_end;
    assign track_din   = px_addr + fmap_pkg::px_addr_t'(fmap_pkg::SEG_PIXELS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            width_q    <= '0;
            height_q   <= '0;
            num_fmap_q <= '0;
            col        <= '0;
            row        <= '0;
            fmap       <= '0;
            px_addr    <= '0;
        end else if (start) begin
            width_q    <= cfg_width;
            height_q   <= cfg_height;
            num_fmap_q <= cfg_num_fmap;
            col        <= '0;
            row        <= '0;
            fmap       <= '0;
            px_addr    <= '0;
        end else if (seg_done) begin
            px_addr <= track_din;
            col     <= col_wrap ? '0 : col_sum[$bits(fmap_pkg::dim_t)-1:0];
            if (fmap_wrap) begin
                fmap <= '0;
                row  <= row + 1'b1;
            end else if (col_wrap) begin
                fmap <= fmap + 1'b1;
            end
        end
    end

endmodule

/* hdl/decode_ctrl.sv */
`timescale 1ns/100ps

module decode_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  fmap_pkg::mem_addr_t         cfg_read_addr,
    input  logic                        mem_grant,
    input  logic                        mem_vld,
    input  logic                        mem_fin,
    input  logic                        px_grant,
    input  logic                        pop_done,
    input  fmap_pkg::pop_count_t        pop_count,
    input  logic                        expand_done,
    input  logic                        row_end,
    input  logic                        frame_end,
    output logic                        mem_req,
    output fmap_pkg::mem_addr_t         mem_addr,
    output logic [fmap_pkg::LEN_W-1:0]  mem_len,
    output logic                        map_load,
    output logic                        word_push,
    output logic                        expand_start,
    output logic                        px_req,
    output logic                        px_wr_vld,
    output logic                        px_pop,
    output logic                        seg_done,
    output logic                        busy,
    output logic                        done
);

    typedef enum logic [3:0] {
        S_IDLE, S_MAP_REQ, S_MAP_WAIT, S_POP_WAIT, S_PIX_REQ,
        S_PIX_WAIT, S_EXPAND, S_PX_REQ, S_BURST, S_ADVANCE
    } state_t;

    state_t                       state;
    logic [fmap_pkg::LEN_W-1:0]   pix_words;
    logic [$clog2(fmap_pkg::SEG_PIXELS)-1:0] beat;
    fmap_pkg::pop_count_t         pop_round;

    assign pop_round = pop_count + 5'd1;  // ceil(w/2) from bits [4:1]

    assign mem_req      = (state == S_MAP_REQ) || (state == S_PIX_REQ);
    assign mem_len      = (state == S_PIX_REQ) ? pix_words
                                               : {{(fmap_pkg::LEN_W-1){1'b0}}, 1'b1};
    assign map_load     = (state == S_MAP_WAIT) && mem_vld;
    assign word_push    = (state == S_PIX_WAIT) && mem_vld;
    assign expand_start = ((state == S_POP_WAIT) && pop_done && (pop_count == '0)) ||
                          ((state == S_PIX_WAIT) && mem_vld && mem_fin);
    assign px_req       = (state == S_PX_REQ);
    assign px_wr_vld    = (state == S_BURST);
    assign px_pop       = (state == S_BURST);
    assign seg_done     = (state == S_ADVANCE);
    assign busy         = (state != S_IDLE);
    // frame_end only means the current row is the last one
    assign done         = seg_done && row_end && frame_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            mem_addr  <= '0;
            pix_words <= '0;
            beat      <= '0;
        end else begin
            case (state)
                S_IDLE: if (start) begin
                    mem_addr <= cfg_read_addr;
                    state    <= S_MAP_REQ;
                end
                S_MAP_REQ: if (mem_grant) state <= S_MAP_WAIT;
                S_MAP_WAIT: if (mem_vld) begin
                    mem_addr <= mem_addr + fmap_pkg::mem_addr_t'(4);  // past the map word
                    state    <= S_POP_WAIT;
                end
                S_POP_WAIT: if (pop_done) begin
                    pix_words <= pop_round[4:1];
                    state     <= (pop_count == '0) ? S_EXPAND : S_PIX_REQ;
                end
                S_PIX_REQ: if (mem_grant) state <= S_PIX_WAIT;
                S_PIX_WAIT: if (mem_vld && mem_fin) begin
                    mem_addr <= mem_addr + fmap_pkg::mem_addr_t'({pix_words, 2'b00});
                    state    <= S_EXPAND;
                end
                S_EXPAND: if (expand_done) state <= S_PX_REQ;
                S_PX_REQ: if (px_grant) begin
                    beat  <= '0;
                    state <= S_BURST;
                end
                S_BURST: begin
                    beat <= beat + 1'b1;
                    if (&beat) state <= S_ADVANCE;  // 16th beat
                end
                S_ADVANCE: state <= done ? S_IDLE : S_MAP_REQ;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* hdl/sparse_fmap_loader.sv */
`timescale 1ns/100ps

module sparse_fmap_loader #(
    parameter int WORD_FIFO_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  fmap_pkg::mem_addr_t          cfg_read_addr,
    input  fmap_pkg::dim_t               cfg_width,
    input  fmap_pkg::dim_t               cfg_height,
    input  fmap_pkg::fmap_cnt_t          cfg_num_fmap,
    output logic                         mem_req,
    output fmap_pkg::mem_addr_t          mem_addr,
    output logic [fmap_pkg::LEN_W-1:0]   mem_len,
    input  logic                         mem_grant,
    input  fmap_pkg::mem_word_t          mem_din,
    input  logic                         mem_vld,
    input  logic                         mem_fin,
    output logic                         px_req,
    input  logic                         px_grant,
    output fmap_pkg::px_addr_t           px_addr,
    output logic                         px_wr_vld,
    output fmap_pkg::pixel_t             px_dout,
    output logic                         track_write,
    output fmap_pkg::px_addr_t           track_din,
    output logic                         busy,
    output logic                         done
);

    logic                   map_load;
    logic                   pop_done;
    fmap_pkg::pop_count_t   pop_count;
    logic                   word_push;
    logic                   word_pop;
    logic                   word_empty;
    fmap_pkg::mem_word_t    word_data;
    logic                   expand_start;
    logic                   expand_done;
    logic                   pixel_push;
    fmap_pkg::pixel_t       pixel_out;
    logic                   px_pop;
    logic                   seg_done;
    logic                   row_end;
    logic                   frame_end;
    fmap_pkg::sparsity_map_t map_in;

    assign map_in = mem_din[fmap_pkg::MEM_DATA_W-1 -: fmap_pkg::MAP_W];  // map in upper half

    decode_ctrl i_decode_ctrl (
        .clk, .rst_n, .start, .cfg_read_addr,
        .mem_grant, .mem_vld, .mem_fin, .px_grant,
        .pop_done, .pop_count, .expand_done, .row_end, .frame_end,
        .mem_req, .mem_addr, .mem_len, .map_load, .word_push, .expand_start,
        .px_req, .px_wr_vld, .px_pop, .seg_done, .busy, .done
    );

    popcount_unit i_popcount_unit (
        .clk, .rst_n, .map_load, .map_in, .pop_done, .pop_count
    );

    sync_fifo #(
        .payload_t (fmap_pkg::mem_word_t),
        .DEPTH     (WORD_FIFO_DEPTH)
    ) i_word_fifo (
        .clk, .rst_n,
        .push      (word_push),
        .push_data (mem_din),
        .pop       (word_pop),
        .pop_data  (word_data),
        .empty     (word_empty)
    );

    pixel_expander i_pixel_expander (
        .clk, .rst_n, .map_load, .map_in, .expand_start, .word_data, .word_empty,
        .word_pop, .pixel_push, .pixel_out, .expand_done
    );

    // holds one expanded segment until the burst drains it
    sync_fifo #(
        .payload_t (fmap_pkg::pixel_t),
        .DEPTH     (fmap_pkg::SEG_PIXELS)
    ) i_pixel_fifo (
        .clk, .rst_n,
        .push      (pixel_push),
        .push_data (pixel_out),
        .pop       (px_pop),
        .pop_data  (px_dout),
        .empty     ()
    );

    position_tracker i_position_tracker (
        .clk, .rst_n, .start, .cfg_width, .cfg_height, .cfg_num_fmap, .seg_done,
        .px_addr, .row_end, .frame_end, .track_write, .track_din
    );

endmodule

/* include/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// one step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic check_equal(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] expected
);
    if (got !== expected) begin
        $display("MISMATCH at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end_with_failure();
    end
endtask

`endif

/* verif/tb_sparse_fmap_loader.sv */
`timescale 1ns/100ps

module tb_sparse_fmap_loader;

    localparam logic [31:0] SEED = 32'd20;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    fmap_pkg::mem_addr_t        cfg_read_addr;
    fmap_pkg::dim_t             cfg_width;
    fmap_pkg::dim_t             cfg_height;
    fmap_pkg::fmap_cnt_t        cfg_num_fmap;
    logic                       mem_req;
    fmap_pkg::mem_addr_t        mem_addr;
    logic [fmap_pkg::LEN_W-1:0] mem_len;
    logic                       mem_grant;
    fmap_pkg::mem_word_t        mem_din;
    logic                       mem_vld;
    logic                       mem_fin;
    logic                       px_req;
    logic                       px_grant;
    fmap_pkg::px_addr_t         px_addr;
    logic                       px_wr_vld;
    fmap_pkg::pixel_t           px_dout;
    logic                       track_write;
    fmap_pkg::px_addr_t         track_din;
    logic                       busy;
    logic                       done;

    // compressed frame and expected results of the current run
    fmap_pkg::mem_word_t frame_mem [256];
    fmap_pkg::pixel_t    exp_pix [512];
    logic [31:0]         exp_rd_addr [$];
    logic [31:0]         exp_rd_len [$];
    logic [31:0]         exp_track [$];
    logic [31:0]         base_addr;
    int                  num_segs;
    int                  burst_cnt;
    int                  track_cnt;
    int                  cycles;
    int                  budget;
    logic [31:0]         rng_gen;
    logic [31:0]         rng_mem;
    logic [31:0]         rng_px;

    sparse_fmap_loader #(.WORD_FIFO_DEPTH(8)) i_sparse_fmap_loader (.*);

    task automatic end_with_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    `include "tb_util.svh"

    task automatic drive_step();  // rising edge plus input delay
        @(posedge clk);
        #5;
    endtask

    function automatic int count_ones(input logic [15:0] m);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) n += int'(m[i]);
        return n;
    endfunction

    task automatic build_frame(input int run);
        logic [15:0] seg_map;
        logic [15:0] stored [16];
        int          wp;
        int          w;
        int          nwords;
        int          nxt;
        int          segs_per_row;
        exp_rd_addr.delete();
        exp_rd_len.delete();
        exp_track.delete();
        rng_gen = xorshift(rng_gen);
        cfg_width = fmap_pkg::dim_t'(1 + rng_gen % 40);
        rng_gen = xorshift(rng_gen);
        cfg_height = fmap_pkg::dim_t'(2 + rng_gen % 2);
        rng_gen = xorshift(rng_gen);
        cfg_num_fmap = fmap_pkg::fmap_cnt_t'(2 + rng_gen % 2);
        rng_gen = xorshift(rng_gen);
        base_addr = 32'h0004_0000 + {rng_gen[13:2], 2'b00};
        cfg_read_addr = base_addr;
        segs_per_row = int'(cfg_num_fmap) * ((int'(cfg_width) + 15) / 16);
        num_segs = segs_per_row * int'(cfg_height);
        wp = 0;
        for (int k = 0; k < num_segs; k++) begin
            rng_gen = xorshift(rng_gen);
            case ((k + run) % 4)
                0: seg_map = 16'hffff;
                1: seg_map = 16'h0000;
                2: seg_map = 16'h0001 << rng_gen[3:0];  // a single pixel for an odd count
                default: seg_map = rng_gen[31:16];
            endcase
            w = count_ones(seg_map);
            exp_rd_addr.push_back(base_addr + 4 * wp);
            exp_rd_len.push_back(1);
            frame_mem[wp] = {seg_map, rng_gen[15:0]};  // lower half unused
            wp++;
            for (int i = 0; i < w; i++) begin
                rng_gen = xorshift(rng_gen);
                stored[i] = (rng_gen[15:0] == 16'h0) ? 16'h0001 : rng_gen[15:0];
            end
            // map bit 15 is column 0
            nxt = 0;
            for (int c = 0; c < 16; c++) begin
                exp_pix[k * 16 + c] = seg_map[15 - c] ? stored[nxt] : 16'h0000;
                if (seg_map[15 - c]) nxt++;
            end
            nwords = (w + 1) / 2;
            if (nwords > 0) begin
                exp_rd_addr.push_back(base_addr + 4 * wp);
                exp_rd_len.push_back(nwords);
            end
            for (int j = 0; j < nwords; j++) begin
                rng_gen = xorshift(rng_gen);  // padding when w is odd
                frame_mem[wp] = {(2 * j + 1 < w) ? stored[2 * j + 1] : rng_gen[15:0],
                                 stored[2 * j]};
                wp++;
            end
        end
        for (int r = 1; r <= int'(cfg_height); r++) begin
            exp_track.push_back(r * segs_per_row * 16);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : mem_responder
        int idx;
        int len;
        mem_grant = 1'b0;
        mem_din   = '0;
        mem_vld   = 1'b0;
        mem_fin   = 1'b0;
        rng_mem   = SEED ^ 32'h0000_0a5a;  // own stream from the same seed
        forever begin
            @(negedge clk);
            if (mem_req === 1'b1) begin
                rng_mem = xorshift(rng_mem);
                repeat (rng_mem % 4) @(negedge clk);
                drive_step();
                mem_grant = 1'b1;
                @(negedge clk);
                if (exp_rd_addr.size() == 0) begin
                    $display("unexpected memory read at address %0h", mem_addr);
                    end_with_failure();
                end
                check_equal("mem_req", 32'(mem_req), 32'd1);
                check_equal("mem_addr", mem_addr, exp_rd_addr.pop_front());
                check_equal("mem_len", 32'(mem_len), exp_rd_len.pop_front());
                idx = int'((mem_addr - base_addr) >> 2);
                len = int'(mem_len);
                drive_step();
                mem_grant = 1'b0;
                for (int i = 0; i < len; i++) begin
                    rng_mem = xorshift(rng_mem);
                    repeat (rng_mem % 3) drive_step();  // gap before the word
                    mem_din = frame_mem[idx + i];
                    mem_vld = 1'b1;
                    mem_fin = (i == len - 1);
                    drive_step();
                    mem_vld = 1'b0;
                    mem_fin = 1'b0;
                end
            end
        end
    end

    initial begin : pixel_sink
        px_grant = 1'b0;
        rng_px   = SEED ^ 32'h0000_c3c3;
        forever begin
            @(negedge clk);
            if (px_req === 1'b1) begin
                rng_px = xorshift(rng_px);
                repeat (rng_px % 5) @(negedge clk);
                drive_step();
                px_grant = 1'b1;
                drive_step();
                px_grant = 1'b0;
                if (burst_cnt >= num_segs) begin
                    $display("more pixel bursts than segments in the frame");
                    end_with_failure();
                end
                for (int b = 0; b < fmap_pkg::SEG_PIXELS; b++) begin
                    @(negedge clk);
                    check_equal("px_wr_vld", 32'(px_wr_vld), 32'd1);
                    check_equal("px_addr", 32'(px_addr), 32'(burst_cnt * 16));
                    check_equal("px_dout", 32'(px_dout), 32'(exp_pix[burst_cnt * 16 + b]));
                end
                @(negedge clk);
                check_equal("px_wr_vld", 32'(px_wr_vld), 32'd0);  // exactly 16 beats
                burst_cnt++;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && track_write === 1'b1) begin
            if (exp_track.size() == 0) begin
                $display("track_write pulsed more often than there are rows");
                end_with_failure();
            end
            check_equal("track_din", 32'(track_din), exp_track.pop_front());
            track_cnt++;
        end
    end

    // watchdog with the budget set per run
    always @(posedge clk) begin
        cycles++;
        if (cycles > budget) begin
            $display("timeout, run did not finish within %0d cycles", budget);
            end_with_failure();
        end
    end

    initial begin : main_seq
        start         = 1'b0;
        cfg_read_addr = '0;
        cfg_width     = '0;
        cfg_height    = '0;
        cfg_num_fmap  = '0;
        rst_n         = 1'b0;
        rng_gen       = SEED;
        cycles        = 0;
        budget        = 100;
        burst_cnt     = 0;
        track_cnt     = 0;
        num_segs      = 0;
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int run = 0; run < 2; run++) begin
            drive_step();
            build_frame(run);
            burst_cnt = 0;
            track_cnt = 0;
            cycles    = 0;
            budget    = 200 * num_segs;
            start     = 1'b1;
            drive_step();
            start = 1'b0;
            @(negedge clk);
            while (done !== 1'b1) begin
                check_equal("busy", 32'(busy), 32'd1);
                @(negedge clk);
            end
            check_equal("busy", 32'(busy), 32'd1);
            @(negedge clk);
            // back in idle one cycle later
            check_equal("done", 32'(done), 32'd0);
            check_equal("busy", 32'(busy), 32'd0);
            check_equal("mem_req", 32'(mem_req), 32'd0);
            check_equal("px_req", 32'(px_req), 32'd0);
            check_equal("px_wr_vld", 32'(px_wr_vld), 32'd0);
            check_equal("track_write", 32'(track_write), 32'd0);
            check_equal("burst count", 32'(burst_cnt), 32'(num_segs));
            check_equal("track_write count", 32'(track_cnt), 32'(cfg_height));
            check_equal("reads outstanding", 32'(exp_rd_addr.size()), 32'd0);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* all.f */
hdl/fmap_pkg.sv
hdl/sync_fifo.sv
hdl/popcount_unit.sv
hdl/pixel_expander.sv
hdl/position_tracker.sv
hdl/decode_ctrl.sv
hdl/sparse_fmap_loader.sv
+incdir+include
verif/tb_sparse_fmap_loader.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary -j 0 -Wno-fatal
TOP       = tb_sparse_fmap_loader
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
